/* common/gb_sys_cfg.svh */
`ifndef GB_SYS_CFG_SVH
`define GB_SYS_CFG_SVH

// bus and storage widths
`define GB_ADDR_W    16
`define GB_DATA_W    8
`define GB_IRQ_N     5
`define GB_WRAM_AW   15 // 8 banks of 4 KiB
`define GB_HRAM_AW   7  // ff80-fffe, top entry unused
`define GB_WBANK_W   3

// ----------------------------------------
// register addresses
// ----------------------------------------
`define GB_REG_JOY   16'hFF00
`define GB_REG_IF    16'hFF0F
`define GB_REG_KEY0  16'hFF4C // cpu mode, boot rom only
`define GB_REG_KEY1  16'hFF4D // speed switch
`define GB_REG_BOOT  16'hFF50
`define GB_REG_SVBK  16'hFF70
`define GB_REG_FF72  16'hFF72
`define GB_REG_FF73  16'hFF73
`define GB_REG_FF74  16'hFF74
`define GB_REG_FF75  16'hFF75
`define GB_REG_IE    16'hFFFF

// interrupt vectors, 40 48 50 58 60
`define GB_VEC_BASE  8'h40
`define GB_VEC_STEP  8'h08

`define GB_OPEN_BUS  8'hFF // pulled-up data bus

`endif

/* common/gb_sys_pkg.sv */
`default_nettype none

`include "gb_sys_cfg.svh"

package gb_sys_pkg;

	typedef logic [`GB_ADDR_W-1:0]  gb_addr_t;  // cpu address
	typedef logic [`GB_DATA_W-1:0]  gb_data_t;  // one bus byte

	// one bit per source
	// 0 vblank, 1 lcd stat, 2 timer, 3 serial, 4 joypad
	typedef logic [`GB_IRQ_N-1:0]   gb_irq_t;

	typedef logic [`GB_WBANK_W-1:0] gb_wbank_t; // svbk bank number

endpackage

`default_nettype wire

/* filelist.f */
+incdir+common
common/gb_sys_pkg.sv
rtl/gb_bus_decode.sv
rtl/gb_irq_ctrl.sv
rtl/gb_io_regs.sv
memory/gb_int_ram.sv
rtl/gb_read_mux.sv
rtl/gb_sys_core.sv
verif/gb_sys_checker.sv
verif/gb_sys_asserts.sv
verif/gb_sys_tb.sv

/* memory/gb_int_ram.sv */
`default_nettype none

`include "gb_sys_cfg.svh"

module gb_int_ram (
	input  wire                        clk_sys,
	input  wire gb_sys_pkg::gb_addr_t  cpu_addr_i,
	input  wire gb_sys_pkg::gb_data_t  wdata_i,
	input  wire                        wr_stb_i,
	input  wire                        sel_wram_i,
	input  wire                        sel_hram_i,
	input  wire gb_sys_pkg::gb_wbank_t wbank_i,
	input  wire                        is_gbc_i,
	output gb_sys_pkg::gb_data_t       wram_q_o,
	output gb_sys_pkg::gb_data_t       hram_q_o
);

	gb_sys_pkg::gb_data_t  wram_mem [2**`GB_WRAM_AW];
	gb_sys_pkg::gb_data_t  hram_mem [2**`GB_HRAM_AW];
	gb_sys_pkg::gb_wbank_t bank_eff;
	logic [`GB_WRAM_AW-1:0] wram_addr;
	logic [`GB_HRAM_AW-1:0] hram_addr;

	// bank 0 in svbk means bank 1, mono has a fixed bank 1
	assign bank_eff = (!is_gbc_i || wbank_i == '0) ? gb_sys_pkg::gb_wbank_t'(1) : wbank_i;

	// c000-cfff fixed bank 0, d000-dfff switched, e000 mirror folds in via a[12:0]
	assign wram_addr = cpu_addr_i[12] ? {bank_eff, cpu_addr_i[11:0]}
	                                  : {{`GB_WBANK_W{1'b0}}, cpu_addr_i[11:0]};
	assign hram_addr = cpu_addr_i[`GB_HRAM_AW-1:0];

	// ----------------------------------------
	// work ram
	// ----------------------------------------
	always_ff @(posedge clk_sys) begin
		if (wr_stb_i && sel_wram_i)
			wram_mem[wram_addr] <= wdata_i;
		wram_q_o <= wram_mem[wram_addr]; // data one cycle after the address
	end

	// ----------------------------------------
	// high ram
	// ----------------------------------------
	always_ff @(posedge clk_sys) begin
		if (wr_stb_i && sel_hram_i)
			hram_mem[hram_addr] <= wdata_i;
		hram_q_o <= hram_mem[hram_addr];
	end

endmodule

`default_nettype wire

/* rtl/gb_bus_decode.sv */
`default_nettype none

`include "gb_sys_cfg.svh"

module gb_bus_decode (
	input  wire                       clk_sys,
	input  wire                       reset_ss,
	input  wire gb_sys_pkg::gb_addr_t cpu_addr_i,
	input  wire                       cpu_wr_n_i,
	input  wire                       cpu_m1_n_i,
	input  wire                       cpu_iorq_n_i,
	input  wire                       is_gbc_i,
	input  wire                       boot_en_i,   // boot rom still mapped
	input  wire                       cgb_mode_i,  // colour register set visible
	output logic                      sel_wram_o,
	output logic                      sel_hram_o,
	output logic                      sel_ie_o,
	output logic                      sel_if_o,
	output logic                      sel_joy_o,
	output logic                      sel_key0_o,
	output logic                      sel_key1_o,
	output logic                      sel_svbk_o,
	output logic                      sel_boot_o,
	output logic [3:0]                sel_spare_o, // ff72..ff75
	output logic                      wr_stb_o,
	output logic                      irq_ack_o
);

	logic wr_n_d; // write level of the last cycle

	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			wr_n_d <= 1'b0;
		else
			wr_n_d <= cpu_wr_n_i;
	end

	assign wr_stb_o  = wr_n_d & ~cpu_wr_n_i; // falling edge of wr_n, one cycle
	assign irq_ack_o = ~cpu_m1_n_i & ~cpu_iorq_n_i;

	// ----------------------------------------
	// memory regions
	// ----------------------------------------
	// c000-fdff, the e000 half mirrors c000 through the low 13 bits
	assign sel_wram_o = (cpu_addr_i[15:14] == 2'b11) && !(&cpu_addr_i[13:9]);
	assign sel_hram_o = (cpu_addr_i[15:7] == 9'h1FF) && (cpu_addr_i != `GB_REG_IE);

	// ----------------------------------------
	// io registers
	// ----------------------------------------
	assign sel_ie_o   = cpu_addr_i == `GB_REG_IE;
	assign sel_if_o   = cpu_addr_i == `GB_REG_IF;
	assign sel_joy_o  = cpu_addr_i == `GB_REG_JOY;
	assign sel_boot_o = boot_en_i && (cpu_addr_i == `GB_REG_BOOT);

	// colour-only registers, gated here so that they read open elsewhere
	assign sel_key0_o = is_gbc_i && boot_en_i && (cpu_addr_i == `GB_REG_KEY0);
	assign sel_key1_o = is_gbc_i && cgb_mode_i && (cpu_addr_i == `GB_REG_KEY1);
	assign sel_svbk_o = is_gbc_i && cgb_mode_i && (cpu_addr_i == `GB_REG_SVBK);

	assign sel_spare_o[0] = is_gbc_i && (cpu_addr_i == `GB_REG_FF72);
	assign sel_spare_o[1] = is_gbc_i && (cpu_addr_i == `GB_REG_FF73);
	assign sel_spare_o[2] = is_gbc_i && cgb_mode_i && (cpu_addr_i == `GB_REG_FF74);
	assign sel_spare_o[3] = is_gbc_i && (cpu_addr_i == `GB_REG_FF75);

endmodule

`default_nettype wire

/* rtl/gb_io_regs.sv */
`default_nettype none

`include "gb_sys_cfg.svh"

module gb_io_regs (
	input  wire                             clk_sys,
	input  wire                             reset_ss,
	input  wire                             wr_stb_i,
	input  wire                             sel_joy_i,
	input  wire                             sel_key0_i,
	input  wire                             sel_key1_i,
	input  wire                             sel_svbk_i,
	input  wire                             sel_boot_i,
	input  wire [3:0]                       sel_spare_i,
	input  wire gb_sys_pkg::gb_data_t       wdata_i,
	input  wire                             is_gbc_i,
	input  wire                             stop_i,      // cpu executes stop
	output logic [1:0]                      joy_p54_o,   // joypad row select
	output logic [1:0]                      key0_o,      // cpu mode, 00 is cgb
	output logic                            prepare_o,
	output logic                            speed_o,     // 1 double speed
	output gb_sys_pkg::gb_wbank_t           wbank_o,
	output logic                            boot_en_o,
	output logic                            cgb_mode_o,
	output gb_sys_pkg::gb_data_t [3:0]      spare_o      // ff75 at byte 3
);

	gb_sys_pkg::gb_data_t ff72_r;
	gb_sys_pkg::gb_data_t ff73_r;
	gb_sys_pkg::gb_data_t ff74_r;
	logic [2:0]           ff75_r; // only bits 6:4 exist

	// mode register applies once the boot rom is gone
	assign cgb_mode_o = (key0_o == 2'b00) || boot_en_o;

	assign spare_o = {{1'b0, ff75_r, 4'h0}, ff74_r, ff73_r, ff72_r};

	// ----------------------------------------
	// joypad, mode, bank, boot flag
	// ----------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			joy_p54_o <= 2'b00;
			key0_o    <= 2'b00;
			wbank_o   <= '0;
			boot_en_o <= 1'b1; // boot rom mapped out of reset
		end else if (wr_stb_i) begin
			if (sel_joy_i)  joy_p54_o <= wdata_i[5:4];
			if (sel_key0_i) key0_o    <= wdata_i[3:2];
			if (sel_svbk_i) wbank_o   <= wdata_i[`GB_WBANK_W-1:0];
			if (sel_boot_i) boot_en_o <= 1'b0;    // any value unmaps it for good
		end
	end

	// ----------------------------------------
	// key1 speed switch
	// ----------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			prepare_o <= 1'b0;
			speed_o   <= 1'b0;
		end else begin
			if (wr_stb_i && sel_key1_i)
				prepare_o <= wdata_i[0];
			// stop with prepare armed flips the speed and disarms
			if (stop_i && is_gbc_i && prepare_o) begin
				speed_o   <= ~speed_o;
				prepare_o <= 1'b0;
			end
		end
	end

	// spare scratch registers
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			ff72_r <= '0;
			ff73_r <= '0;
			ff74_r <= '0;
			ff75_r <= '0;
		end else if (wr_stb_i) begin
			if (sel_spare_i[0]) ff72_r <= wdata_i;
			if (sel_spare_i[1]) ff73_r <= wdata_i;
			if (sel_spare_i[2]) ff74_r <= wdata_i;
			if (sel_spare_i[3]) ff75_r <= wdata_i[6:4];
		end
	end

endmodule

`default_nettype wire

/* rtl/gb_irq_ctrl.sv */
`default_nettype none

`include "gb_sys_cfg.svh"

module gb_irq_ctrl (
	input  wire                       clk_sys,
	input  wire                       reset_ss,
	input  wire gb_sys_pkg::gb_irq_t  irq_evt_i,  // bit 4 comes from the joypad lines instead
	input  wire [3:0]                 joy_din_i,  // p10..p13, active low
	input  wire                       irq_ack_i,
	input  wire                       wr_stb_i,
	input  wire                       sel_ie_i,
	input  wire                       sel_if_i,
	input  wire gb_sys_pkg::gb_data_t wdata_i,
	output gb_sys_pkg::gb_data_t      ie_o,
	output gb_sys_pkg::gb_irq_t       if_o,
	output gb_sys_pkg::gb_data_t      vec_o,
	output logic                      irq_n_o
);

	gb_sys_pkg::gb_data_t ie_r;     // all 8 bits writable, top 3 unused
	gb_sys_pkg::gb_irq_t  if_r;
	gb_sys_pkg::gb_irq_t  pend;     // enabled and flagged
	gb_sys_pkg::gb_irq_t  clr_mask; // one-hot of the winning source
	gb_sys_pkg::gb_irq_t  if_set;
	logic [3:0]           evt_d;
	logic [3:0]           joy_s1;
	logic [3:0]           joy_s2;
	logic [3:0]           joy_s3;
	logic                 ack_d;
	logic                 ack_fall;

	assign pend    = if_r & ie_r[`GB_IRQ_N-1:0];
	assign irq_n_o = ~|pend;

	// lowest index wins, so scan from the top and let lower bits overwrite
	always_comb begin
		vec_o    = '0;
		clr_mask = '0;
		for (int i = `GB_IRQ_N - 1; i >= 0; i--) begin
			if (pend[i]) begin
				vec_o       = 8'(`GB_VEC_BASE + `GB_VEC_STEP * i);
				clr_mask    = '0;
				clr_mask[i] = 1'b1;
			end
		end
	end

	// rising edge of the events, falling edge on any joypad line after two sync stages
	assign if_set   = {|(~joy_s2 & joy_s3), irq_evt_i[3:0] & ~evt_d};
	assign ack_fall = ack_d & ~irq_ack_i; // cpu leaves the ack cycle

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			ie_r   <= '0;
			if_r   <= '0;
			evt_d  <= '0;
			joy_s1 <= '0;
			joy_s2 <= '0;
			joy_s3 <= '0;
			ack_d  <= 1'b0;
		end else begin
			evt_d  <= irq_evt_i[3:0];
			joy_s1 <= joy_din_i;
			joy_s2 <= joy_s1;
			joy_s3 <= joy_s2;
			ack_d  <= irq_ack_i;

			// clear beats a set landing in the same cycle
			if_r <= (if_r | if_set) & ~({`GB_IRQ_N{ack_fall}} & clr_mask);

			// cpu writes come last and override the above
			if (wr_stb_i && sel_ie_i)
				ie_r <= wdata_i;
			if (wr_stb_i && sel_if_i)
				if_r <= wdata_i[`GB_IRQ_N-1:0];
		end
	end

	assign ie_o = ie_r;
	assign if_o = if_r;

endmodule

`default_nettype wire

/* rtl/gb_read_mux.sv */
`default_nettype none

`include "gb_sys_cfg.svh"

module gb_read_mux (
	input  wire                              sel_wram_i,
	input  wire                              sel_hram_i,
	input  wire                              sel_ie_i,
	input  wire                              sel_if_i,
	input  wire                              sel_joy_i,
	input  wire                              sel_key0_i,
	input  wire                              sel_key1_i,
	input  wire                              sel_svbk_i,
	input  wire [3:0]                        sel_spare_i,
	input  wire                              irq_ack_i,
	input  wire gb_sys_pkg::gb_data_t        vec_i,
	input  wire gb_sys_pkg::gb_data_t        ie_i,
	input  wire gb_sys_pkg::gb_irq_t         if_i,
	input  wire [1:0]                        joy_p54_i,
	input  wire [3:0]                        joy_din_i,
	input  wire [1:0]                        key0_i,
	input  wire                              prepare_i,
	input  wire                              speed_i,
	input  wire gb_sys_pkg::gb_wbank_t       wbank_i,
	input  wire gb_sys_pkg::gb_data_t [3:0]  spare_i,
	input  wire gb_sys_pkg::gb_data_t        wram_q_i,
	input  wire gb_sys_pkg::gb_data_t        hram_q_i,
	output gb_sys_pkg::gb_data_t             cpu_rdata_o
);

	// unimplemented bits read back as 1
	always_comb begin
		if (irq_ack_i)           cpu_rdata_o = vec_i;      // vector fetch beats any address
		else if (sel_if_i)       cpu_rdata_o = {3'b111, if_i};
		else if (sel_svbk_i)     cpu_rdata_o = {5'h1F, wbank_i};
		else if (sel_key0_i)     cpu_rdata_o = {4'hF, key0_i, 2'b10};
		else if (sel_key1_i)     cpu_rdata_o = {speed_i, 6'h3F, prepare_i};
		else if (sel_joy_i)      cpu_rdata_o = {2'b11, joy_p54_i, joy_din_i};
		else if (sel_wram_i)     cpu_rdata_o = wram_q_i;
		else if (sel_hram_i)     cpu_rdata_o = hram_q_i;
		else if (sel_ie_i)       cpu_rdata_o = ie_i;
		else if (sel_spare_i[0]) cpu_rdata_o = spare_i[0];
		else if (sel_spare_i[1]) cpu_rdata_o = spare_i[1];
		else if (sel_spare_i[2]) cpu_rdata_o = spare_i[2];
		else if (sel_spare_i[3]) cpu_rdata_o = spare_i[3] | 8'h8F; // only 6:4 stored
		else                     cpu_rdata_o = `GB_OPEN_BUS;
	end

endmodule

`default_nettype wire

/* rtl/gb_sys_core.sv */
`default_nettype none

`include "gb_sys_cfg.svh"

module gb_sys_core (
	input  wire                       clk_sys,
	input  wire                       reset_ss,
	input  wire gb_sys_pkg::gb_addr_t cpu_addr_i,
	input  wire gb_sys_pkg::gb_data_t cpu_wdata_i,
	input  wire                       cpu_rd_n_i,
	input  wire                       cpu_wr_n_i,
	input  wire                       cpu_m1_n_i,
	input  wire                       cpu_iorq_n_i,
	input  wire                       is_gbc_i,
	input  wire                       stop_i,
	input  wire gb_sys_pkg::gb_irq_t  irq_evt_i,
	input  wire [3:0]                 joy_din_i,
	output gb_sys_pkg::gb_data_t      cpu_rdata_o,
	output logic                      irq_n_o,
	output logic [1:0]                joy_p54_o,
	output logic                      speed_o
);

	// selects and strobes
	logic sel_wram, sel_hram, sel_ie, sel_if, sel_joy;
	logic sel_key0, sel_key1, sel_svbk, sel_boot;
	logic [3:0] sel_spare;
	logic wr_stb;
	logic irq_ack;

	// register state
	logic                            boot_en;
	logic                            cgb_mode;
	logic [1:0]                      key0;
	logic                            prepare;
	gb_sys_pkg::gb_wbank_t           wbank;
	gb_sys_pkg::gb_data_t [3:0]      spare;
	gb_sys_pkg::gb_data_t            ie;
	gb_sys_pkg::gb_irq_t             if_flags;
	gb_sys_pkg::gb_data_t            vec;
	gb_sys_pkg::gb_data_t            wram_q;
	gb_sys_pkg::gb_data_t            hram_q;
	gb_sys_pkg::gb_data_t            mux_data;

	// ----------------------------------------
	// decode
	// ----------------------------------------
	gb_bus_decode u_decode (
		.clk_sys      (clk_sys),
		.reset_ss     (reset_ss),
		.cpu_addr_i   (cpu_addr_i),
		.cpu_wr_n_i   (cpu_wr_n_i),
		.cpu_m1_n_i   (cpu_m1_n_i),
		.cpu_iorq_n_i (cpu_iorq_n_i),
		.is_gbc_i     (is_gbc_i),
		.boot_en_i    (boot_en),
		.cgb_mode_i   (cgb_mode),
		.sel_wram_o   (sel_wram),
		.sel_hram_o   (sel_hram),
		.sel_ie_o     (sel_ie),
		.sel_if_o     (sel_if),
		.sel_joy_o    (sel_joy),
		.sel_key0_o   (sel_key0),
		.sel_key1_o   (sel_key1),
		.sel_svbk_o   (sel_svbk),
		.sel_boot_o   (sel_boot),
		.sel_spare_o  (sel_spare),
		.wr_stb_o     (wr_stb),
		.irq_ack_o    (irq_ack)
	);

	// ----------------------------------------
	// execute
	// ----------------------------------------
	gb_irq_ctrl u_irq (
		.clk_sys   (clk_sys),
		.reset_ss  (reset_ss),
		.irq_evt_i (irq_evt_i),
		.joy_din_i (joy_din_i),
		.irq_ack_i (irq_ack),
		.wr_stb_i  (wr_stb),
		.sel_ie_i  (sel_ie),
		.sel_if_i  (sel_if),
		.wdata_i   (cpu_wdata_i),
		.ie_o      (ie),
		.if_o      (if_flags),
		.vec_o     (vec),
		.irq_n_o   (irq_n_o)
	);

	gb_io_regs u_regs (
		.clk_sys     (clk_sys),
		.reset_ss    (reset_ss),
		.wr_stb_i    (wr_stb),
		.sel_joy_i   (sel_joy),
		.sel_key0_i  (sel_key0),
		.sel_key1_i  (sel_key1),
		.sel_svbk_i  (sel_svbk),
		.sel_boot_i  (sel_boot),
		.sel_spare_i (sel_spare),
		.wdata_i     (cpu_wdata_i),
		.is_gbc_i    (is_gbc_i),
		.stop_i      (stop_i),
		.joy_p54_o   (joy_p54_o),
		.key0_o      (key0),
		.prepare_o   (prepare),
		.speed_o     (speed_o),
		.wbank_o     (wbank),
		.boot_en_o   (boot_en),
		.cgb_mode_o  (cgb_mode),
		.spare_o     (spare)
	);

	gb_int_ram u_ram (
		.clk_sys    (clk_sys),
		.cpu_addr_i (cpu_addr_i),
		.wdata_i    (cpu_wdata_i),
		.wr_stb_i   (wr_stb),
		.sel_wram_i (sel_wram),
		.sel_hram_i (sel_hram),
		.wbank_i    (wbank),
		.is_gbc_i   (is_gbc_i),
		.wram_q_o   (wram_q),
		.hram_q_o   (hram_q)
	);

	// ----------------------------------------
	// result
	// ----------------------------------------
	gb_read_mux u_rmux (
		.sel_wram_i  (sel_wram),
		.sel_hram_i  (sel_hram),
		.sel_ie_i    (sel_ie),
		.sel_if_i    (sel_if),
		.sel_joy_i   (sel_joy),
		.sel_key0_i  (sel_key0),
		.sel_key1_i  (sel_key1),
		.sel_svbk_i  (sel_svbk),
		.sel_spare_i (sel_spare),
		.irq_ack_i   (irq_ack),
		.vec_i       (vec),
		.ie_i        (ie),
		.if_i        (if_flags),
		.joy_p54_i   (joy_p54_o),
		.joy_din_i   (joy_din_i),
		.key0_i      (key0),
		.prepare_i   (prepare),
		.speed_i     (speed_o),
		.wbank_i     (wbank),
		.spare_i     (spare),
		.wram_q_i    (wram_q),
		.hram_q_i    (hram_q),
		.cpu_rdata_o (mux_data)
	);

	// bus idles high unless the cpu reads or takes a vector
	assign cpu_rdata_o = (cpu_rd_n_i && !irq_ack) ? `GB_OPEN_BUS : mux_data;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module gb_sys_tb -f filelist.f -o gb_sys_sim || exit 1
out=$(./obj_dir/gb_sys_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "Simulation finished: PASS" && exit 0 || exit 1

/* verif/gb_sys_asserts.sv */
`default_nettype none

module gb_sys_asserts (
	input wire        clk_sys,
	input wire        reset_ss,
	input wire [15:0] cpu_addr_i,
	input wire        cpu_rd_n_i,
	input wire [7:0]  cpu_rdata_o,
	input wire        irq_n_o,
	input wire        stop_i,
	input wire        speed_o
);

	irq_idle_after_reset: assert property (@(posedge clk_sys) reset_ss |=> irq_n_o)
		else $error("irq_n_o low right after reset");

	// second cycle of a held read, ram data has settled
	rdata_known: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(!cpu_rd_n_i && $past(!cpu_rd_n_i) && $stable(cpu_addr_i)) |-> !$isunknown(cpu_rdata_o))
		else $error("cpu_rdata_o unknown during a read");

	speed_on_stop: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(speed_o != $past(speed_o)) |-> $past(stop_i))
		else $error("speed_o changed without stop");

endmodule

bind gb_sys_core gb_sys_asserts u_asserts (
	.clk_sys     (clk_sys),
	.reset_ss    (reset_ss),
	.cpu_addr_i  (cpu_addr_i),
	.cpu_rd_n_i  (cpu_rd_n_i),
	.cpu_rdata_o (cpu_rdata_o),
	.irq_n_o     (irq_n_o),
	.stop_i      (stop_i),
	.speed_o     (speed_o)
);

`default_nettype wire

/* verif/gb_sys_checker.sv */
`default_nettype none

`include "gb_sys_cfg.svh"

module gb_sys_checker (
	input  wire                       clk_sys,
	input  wire                       reset_ss,
	input  wire gb_sys_pkg::gb_addr_t cpu_addr_i,
	input  wire gb_sys_pkg::gb_data_t cpu_wdata_i,
	input  wire                       cpu_wr_n_i,
	input  wire                       cpu_m1_n_i,
	input  wire                       cpu_iorq_n_i,
	input  wire                       is_gbc_i,
	input  wire                       stop_i,
	input  wire gb_sys_pkg::gb_irq_t  irq_evt_i,
	input  wire [3:0]                 joy_din_i,
	input  wire gb_sys_pkg::gb_data_t cpu_rdata_o,
	input  wire                       irq_n_o,
	input  wire [1:0]                 joy_p54_o,
	input  wire                       speed_o,
	input  wire                       sample_i,    // compare read data at this edge
	input  wire [8*12-1:0]            test_i,      // name of the running test
	output int                        err_data_o,
	output int                        err_irq_o,
	output int                        err_joy_o,
	output int                        err_speed_o
);

	// model of the visible state
	gb_sys_pkg::gb_data_t  wram_m [2**`GB_WRAM_AW];
	gb_sys_pkg::gb_data_t  hram_m [2**`GB_HRAM_AW];
	gb_sys_pkg::gb_data_t  spare_m [4];
	gb_sys_pkg::gb_data_t  ie_m;
	gb_sys_pkg::gb_irq_t   if_m;
	gb_sys_pkg::gb_wbank_t wbank_m;
	logic [1:0]            p54_m;
	logic [1:0]            key0_m;
	logic                  prep_m;
	logic                  speed_m;
	logic                  boot_m;
	logic                  prev_wr_n = 1'b1;
	logic                  prev_ack = 1'b0;
	logic [3:0]            evt_d;  // event levels seen at the last edge
	logic [3:0]            j1;     // joypad lines, newest sample
	logic [3:0]            j2;
	logic [3:0]            j3;     // oldest sample

	function automatic logic cgb_on();
		return (key0_m == 2'b00) || boot_m;
	endfunction

	// c000 half is bank 0 and d000 half follows svbk
	// svbk 0 and mono mode both select bank 1
	function automatic int wram_index(input gb_sys_pkg::gb_addr_t a, input logic gbc);
		int bank;
		bank = (!gbc || wbank_m == 0) ? 1 : int'(wbank_m);
		return a[12] ? bank * 4096 + int'(a[11:0]) : int'(a[11:0]);
	endfunction

	// lowest enabled pending source wins
	function automatic gb_sys_pkg::gb_data_t vector_of();
		for (int i = 0; i < `GB_IRQ_N; i++)
			if (if_m[i] && ie_m[i])
				return 8'(`GB_VEC_BASE + `GB_VEC_STEP * i);
		return 8'h00;
	endfunction

	function automatic gb_sys_pkg::gb_data_t expect_read(input gb_sys_pkg::gb_addr_t a,
			input logic gbc, input logic ack, input logic [3:0] joy);
		if (ack)
			return vector_of();
		if (a >= 16'hC000 && a < 16'hFE00)
			return wram_m[wram_index(a, gbc)];
		if (a >= 16'hFF80 && a < 16'hFFFF)
			return hram_m[a[6:0]];
		case (a)
			`GB_REG_IE:   return ie_m;
			`GB_REG_IF:   return {3'b111, if_m};
			`GB_REG_JOY:  return {2'b11, p54_m, joy};
			`GB_REG_KEY0: if (gbc && boot_m) return {4'hF, key0_m, 2'b10};
			`GB_REG_KEY1: if (gbc && cgb_on()) return {speed_m, 6'h3F, prep_m};
			`GB_REG_SVBK: if (gbc && cgb_on()) return {5'h1F, wbank_m};
			`GB_REG_FF72: if (gbc) return spare_m[0];
			`GB_REG_FF73: if (gbc) return spare_m[1];
			`GB_REG_FF74: if (gbc && cgb_on()) return spare_m[2];
			`GB_REG_FF75: if (gbc) return (spare_m[3] & 8'h70) | 8'h8F;
			default: ;
		endcase
		return `GB_OPEN_BUS;
	endfunction

	// ----------------------------------------
	// compare first and advance the model after
	// ----------------------------------------
	always @(posedge clk_sys) begin : track
		logic                 wr;
		logic                 ack;
		logic                 prep_old;
		gb_sys_pkg::gb_irq_t  set;
		gb_sys_pkg::gb_irq_t  clr;
		gb_sys_pkg::gb_data_t exp;
		wr  = prev_wr_n && !cpu_wr_n_i;
		ack = !cpu_m1_n_i && !cpu_iorq_n_i;
		if (reset_ss) begin
			ie_m    = '0;
			if_m    = '0;
			wbank_m = '0;
			p54_m   = '0;
			key0_m  = '0;
			prep_m  = 1'b0;
			speed_m = 1'b0;
			boot_m  = 1'b1; // boot rom mapped
			evt_d   = '0;
			j1      = '0;
			j2      = '0;
			j3      = '0;
			for (int k = 0; k < 4; k++)
				spare_m[k] = '0;
			err_data_o  = 0;
			err_irq_o   = 0;
			err_joy_o   = 0;
			err_speed_o = 0;
		end else begin
			if (sample_i) begin
				exp = expect_read(cpu_addr_i, is_gbc_i, ack, joy_din_i);
				if (cpu_rdata_o !== exp) begin
					err_data_o++;
					$display("[ERROR] %0s read %h: expected %h actual %h",
						test_i, cpu_addr_i, exp, cpu_rdata_o);
				end
			end
			if (irq_n_o !== ~|(if_m & ie_m[`GB_IRQ_N-1:0])) begin
				err_irq_o++;
				$display("[ERROR] %0s irq_n: expected %b actual %b",
					test_i, ~|(if_m & ie_m[`GB_IRQ_N-1:0]), irq_n_o);
			end
			if (joy_p54_o !== p54_m) begin
				err_joy_o++;
				$display("[ERROR] %0s joy_p54: expected %b actual %b",
					test_i, p54_m, joy_p54_o);
			end
			if (speed_o !== speed_m) begin
				err_speed_o++;
				$display("[ERROR] %0s speed: expected %b actual %b", test_i, speed_m, speed_o);
			end

			// events count on a rising level
			for (int i = 0; i < 4; i++)
				set[i] = irq_evt_i[i] && !evt_d[i];
			set[4] = (j3 & ~j2) != 4'h0; // some line went low two samples back

			clr = '0;
			if (prev_ack && !ack) begin // first cycle after the ack
				for (int i = 0; i < `GB_IRQ_N; i++)
					if (clr == '0 && if_m[i] && ie_m[i])
						clr[i] = 1'b1;
			end
			if_m  = (if_m | set) & ~clr;
			evt_d = irq_evt_i[3:0];
			j3 = j2;
			j2 = j1;
			j1 = joy_din_i;

			prep_old = prep_m;
			if (wr) begin
				if (cpu_addr_i >= 16'hC000 && cpu_addr_i < 16'hFE00)
					wram_m[wram_index(cpu_addr_i, is_gbc_i)] = cpu_wdata_i;
				if (cpu_addr_i >= 16'hFF80 && cpu_addr_i < 16'hFFFF)
					hram_m[cpu_addr_i[6:0]] = cpu_wdata_i;
				case (cpu_addr_i)
					`GB_REG_IE:   ie_m = cpu_wdata_i;
					`GB_REG_IF:   if_m = cpu_wdata_i[`GB_IRQ_N-1:0];
					`GB_REG_JOY:  p54_m = cpu_wdata_i[5:4];
					`GB_REG_KEY0: if (is_gbc_i && boot_m) key0_m = cpu_wdata_i[3:2];
					`GB_REG_KEY1: if (is_gbc_i && cgb_on()) prep_m = cpu_wdata_i[0];
					`GB_REG_SVBK: if (is_gbc_i && cgb_on()) wbank_m = cpu_wdata_i[2:0];
					`GB_REG_BOOT: boot_m = 1'b0;
					`GB_REG_FF72: if (is_gbc_i) spare_m[0] = cpu_wdata_i;
					`GB_REG_FF73: if (is_gbc_i) spare_m[1] = cpu_wdata_i;
					`GB_REG_FF74: if (is_gbc_i && cgb_on()) spare_m[2] = cpu_wdata_i;
					`GB_REG_FF75: if (is_gbc_i) spare_m[3] = cpu_wdata_i;
					default: ;
				endcase
			end
			if (stop_i && is_gbc_i && prep_old) begin // speed switch on stop
				speed_m = ~speed_m;
				prep_m  = 1'b0;
			end
		end
		prev_wr_n = cpu_wr_n_i;
		prev_ack  = ack;
	end

endmodule

`default_nettype wire

/* verif/gb_sys_tb.sv */
`default_nettype none

module gb_sys_tb;

	// about 340 bus operations of at most 4 cycles each
	localparam int OP_COUNT    = 127 * 2 + 80;
	localparam int CYC_PER_OP  = 4;
	localparam int TIMEOUT_CYC = OP_COUNT * CYC_PER_OP + 200;

	logic        clk_sys;
	logic        reset_ss;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_wdata;
	logic        cpu_rd_n, cpu_wr_n, cpu_m1_n, cpu_iorq_n;
	logic        is_gbc, stop;
	logic [4:0]  irq_evt;
	logic [3:0]  joy_din;
	logic [7:0]  cpu_rdata;
	logic        irq_n, speed;
	logic [1:0]  joy_p54;
	logic        sample;
	logic [8*12-1:0] test_name;
	int          err_data, err_irq, err_joy, err_speed;
	int          cycle_cnt = 0;
	integer      seed;
	logic [7:0]  rnd;

	gb_sys_core u_gb_sys_core (
		.clk_sys (clk_sys), .reset_ss (reset_ss),
		.cpu_addr_i (cpu_addr), .cpu_wdata_i (cpu_wdata),
		.cpu_rd_n_i (cpu_rd_n), .cpu_wr_n_i (cpu_wr_n),
		.cpu_m1_n_i (cpu_m1_n), .cpu_iorq_n_i (cpu_iorq_n),
		.is_gbc_i (is_gbc), .stop_i (stop), .irq_evt_i (irq_evt), .joy_din_i (joy_din),
		.cpu_rdata_o (cpu_rdata), .irq_n_o (irq_n), .joy_p54_o (joy_p54), .speed_o (speed)
	);

	gb_sys_checker u_checker (
		.clk_sys (clk_sys), .reset_ss (reset_ss),
		.cpu_addr_i (cpu_addr), .cpu_wdata_i (cpu_wdata), .cpu_wr_n_i (cpu_wr_n),
		.cpu_m1_n_i (cpu_m1_n), .cpu_iorq_n_i (cpu_iorq_n),
		.is_gbc_i (is_gbc), .stop_i (stop), .irq_evt_i (irq_evt), .joy_din_i (joy_din),
		.cpu_rdata_o (cpu_rdata), .irq_n_o (irq_n), .joy_p54_o (joy_p54), .speed_o (speed),
		.sample_i (sample), .test_i (test_name),
		.err_data_o (err_data), .err_irq_o (err_irq), .err_joy_o (err_joy),
		.err_speed_o (err_speed)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYC) begin
			$display("timeout: run did not end within %0d cycles", TIMEOUT_CYC);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// ----------------------------------------
	// bus tasks
	// ----------------------------------------
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		cpu_addr  <= a;
		cpu_wdata <= d;
		cpu_wr_n  <= 1'b0; // strobe in this cycle
		@(posedge clk_sys);
		cpu_wr_n  <= 1'b1;
	endtask

	task automatic bus_read(input logic [15:0] a);
		@(posedge clk_sys);
		cpu_addr <= a;
		cpu_rd_n <= 1'b0;
		@(posedge clk_sys);
		sample   <= 1'b1; // checked at the second edge
		@(posedge clk_sys);
		sample   <= 1'b0;
		cpu_rd_n <= 1'b1;
	endtask

	task automatic irq_acknowledge();
		@(posedge clk_sys);
		cpu_m1_n   <= 1'b0;
		cpu_iorq_n <= 1'b0;
		@(posedge clk_sys);
		sample     <= 1'b1;
		@(posedge clk_sys);
		sample     <= 1'b0;
		cpu_m1_n   <= 1'b1;
		cpu_iorq_n <= 1'b1;
		@(posedge clk_sys); // bit clears here
	endtask

	task automatic pulse_event(input int idx);
		@(posedge clk_sys);
		irq_evt[idx] <= 1'b1;
		@(posedge clk_sys);
		irq_evt <= '0;
	endtask

	task automatic pulse_stop();
		@(posedge clk_sys);
		stop <= 1'b1;
		@(posedge clk_sys);
		stop <= 1'b0;
	endtask

	initial begin
		seed       = 32'ha57a_1df4;
		reset_ss   = 1'b1;
		cpu_addr   = '0;
		cpu_wdata  = '0;
		cpu_rd_n   = 1'b1;
		cpu_wr_n   = 1'b1;
		cpu_m1_n   = 1'b1;
		cpu_iorq_n = 1'b1;
		is_gbc     = 1'b1;
		stop       = 1'b0;
		irq_evt    = '0;
		joy_din    = 4'hF; // no key pressed
		sample     = 1'b0;
		test_name  = "reset";
		repeat (2) @(posedge clk_sys);
		reset_ss <= 1'b0;
		wait_cycles(2);

		test_name <= "wram";
		for (int b = 2; b <= 3; b++) begin
			bus_write(16'hFF70, 8'(b));
			bus_write(16'hD000, 8'($random(seed)));
		end
		bus_write(16'hFF70, 8'h02);
		bus_read(16'hD000);
		bus_write(16'hFF70, 8'h03);
		bus_read(16'hD000);
		bus_write(16'hFF70, 8'h00);
		bus_write(16'hD000, 8'($random(seed)));
		bus_write(16'hFF70, 8'h01);
		bus_read(16'hD000); // bank 0 aliases bank 1
		bus_write(16'hC000, 8'($random(seed)));
		bus_read(16'hE000);
		bus_write(16'hFF70, 8'h03); // svbk away from bank 1 before mono
		is_gbc <= 1'b0; // mono mode ignores svbk
		bus_read(16'hFF70);
		bus_read(16'hD000);
		bus_write(16'hD001, 8'($random(seed)));
		is_gbc <= 1'b1;
		bus_write(16'hFF70, 8'h01);
		bus_read(16'hD001);

		test_name <= "hram";
		for (int a = 'hFF80; a <= 'hFFFE; a++)
			bus_write(16'(a), 8'($random(seed)));
		for (int a = 'hFF80; a <= 'hFFFE; a++)
			bus_read(16'(a));
		bus_write(16'hFFFF, 8'h15); // enables vblank, timer and joypad
		bus_read(16'hFFFF);
		bus_read(16'hFFFE);

		test_name <= "irq";
		pulse_event(2);
		pulse_event(0);
		wait_cycles(1);
		bus_read(16'hFF0F);
		irq_acknowledge();
		bus_read(16'hFF0F);
		irq_acknowledge();
		bus_read(16'hFF0F);
		rnd = 8'($random(seed));
		bus_write(16'hFF0F, rnd);
		bus_read(16'hFF0F);
		bus_write(16'hFFFF, 8'($random(seed)));
		irq_acknowledge();
		bus_write(16'hFF0F, 8'h00);

		test_name <= "joypad";
		bus_write(16'hFF00, 8'h20);
		bus_read(16'hFF00);
		@(posedge clk_sys);
		joy_din <= 4'b1110; // line 0 pressed
		wait_cycles(4);
		bus_read(16'hFF0F);
		joy_din <= 4'hF;
		wait_cycles(4);

		test_name <= "key1";
		bus_write(16'hFF4D, 8'h01);
		bus_read(16'hFF4D);
		pulse_stop();
		wait_cycles(1);
		bus_read(16'hFF4D);

		test_name <= "key0_spare";
		for (int a = 'hFF72; a <= 'hFF75; a++) begin
			bus_write(16'(a), 8'($random(seed)));
			bus_read(16'(a));
		end
		bus_write(16'hFF4C, 8'h04);
		bus_read(16'hFF4C);
		bus_write(16'hFF50, 8'h01); // boot flag off freezes key0
		bus_write(16'hFF4C, 8'h00); // would restore cgb mode if key0 still took writes
		bus_read(16'hFF4C);
		bus_read(16'hFF4D);
		bus_read(16'hFF74);
		bus_read(16'hFF01);
		bus_read(16'h8000);
		bus_read(16'hFF4F);
		wait_cycles(4);

		$display("errors: read data %0d, irq_n %0d, joy_p54 %0d, speed %0d",
			err_data, err_irq, err_joy, err_speed);
		if (err_data + err_irq + err_joy + err_speed == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
